// ==== hw/ldp_pkg.sv ====
// Fixed 64-bit bus with small bursts; ring sizes and frame size must be whole bursts
package ldp_pkg;

    // ======================================================================
    // Bus widths
    // ======================================================================
    localparam int DATA_W = 64;
    localparam int ADDR_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // AXI fixed fields; the slave uses INCR bursts of full-width beats
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_FULL  = 3'($clog2(STRB_W));

    // ======================================================================
    // Burst geometry
    // ======================================================================
    localparam int FD_BURST_BYTES = 64;
    localparam int MD_BURST_BYTES = 16;
    localparam int FD_BEATS       = FD_BURST_BYTES >> AXI_SIZE_FULL;
    localparam int MD_BEATS       = MD_BURST_BYTES >> AXI_SIZE_FULL;

    // Frame-data bursts go to one ring this many times before switching rings
    localparam int BURSTS_PER_GROUP = 4;

    // Host-RAM layout, all values in bytes
    typedef struct packed {
        logic [ADDR_W-1:0] fd0_base;
        logic [ADDR_W-1:0] fd1_base;
        logic [ADDR_W-1:0] fd_size;
        logic [ADDR_W-1:0] md0_base;
        logic [ADDR_W-1:0] md1_base;
        logic [ADDR_W-1:0] md_size;
        logic [ADDR_W-1:0] fc_addr;
        logic [ADDR_W-1:0] frame_size;
    } ring_cfg_t;

    // One AW request; size and burst type come from the constants above
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } aw_req_t;

    // One W beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // The two metadata words captured for each frame
    typedef struct packed {
        logic [DATA_W-1:0] word0;
        logic [DATA_W-1:0] word1;
    } md_pair_t;

endpackage

// ==== hw/fd_addr_gen.sv ====
// Ring bases and fd_size must stay fixed while out of reset; fd_size is a whole number of bursts
`timescale 1ns/1ps

module fd_addr_gen (
    input  logic                       clk,
    input  logic                       resetn,
    input  ldp_pkg::ring_cfg_t         cfg,
    input  logic                       fd_step,
    output logic [ldp_pkg::ADDR_W-1:0] fd_addr
);
    import ldp_pkg::*;

    // Position within the ping-pong group, running 1 to 2*BURSTS_PER_GROUP
    logic [$clog2(2*BURSTS_PER_GROUP+1)-1:0] group_cnt;

    // Byte offset of the next burst inside each ring
    logic [ADDR_W-1:0] off0;
    logic [ADDR_W-1:0] off1;

    // High while the second half of the group targets ring 1
    logic ring_sel;

    // Advances an offset by one burst and wraps at the ring size
    function automatic logic [ADDR_W-1:0] next_off(input logic [ADDR_W-1:0] off,
                                                   input logic [ADDR_W-1:0] size);
        logic [ADDR_W-1:0] nxt;
        nxt = off + ADDR_W'(FD_BURST_BYTES);
        return (nxt >= size) ? '0 : nxt;
    endfunction

    assign ring_sel = (group_cnt > BURSTS_PER_GROUP);
    assign fd_addr  = ring_sel ? (cfg.fd1_base + off1) : (cfg.fd0_base + off0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            group_cnt <= 1;
            off0      <= '0;
            off1      <= '0;
        end else if (fd_step) begin
            // Only the ring that was just used moves on
            if (ring_sel)
                off1 <= next_off(off1, cfg.fd_size);
            else
                off0 <= next_off(off0, cfg.fd_size);

            if (group_cnt == $bits(group_cnt)'(2 * BURSTS_PER_GROUP))
                group_cnt <= 1;
            else
                group_cnt <= group_cnt + 1'b1;
        end
    end

    // The offset registers and the group select together keep the
    // address inside the ring that is currently in use
    a_fd_in_ring: assert property (@(posedge clk) disable iff (!resetn)
        ring_sel ? (fd_addr >= cfg.fd1_base && fd_addr < cfg.fd1_base + cfg.fd_size)
                 : (fd_addr >= cfg.fd0_base && fd_addr < cfg.fd0_base + cfg.fd_size))
        else $error("fd_addr 0x%0h is outside the selected ring", fd_addr);

endmodule

// ==== hw/md_capture.sv ====
// Takes exactly two metadata words per frame; frame_start must not come before both are held
`timescale 1ns/1ps

module md_capture (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       frame_start,
    input  logic [ldp_pkg::DATA_W-1:0] md_data,
    input  logic                       md_valid,
    output logic                       md_ready,
    output ldp_pkg::md_pair_t          md,
    output logic                       md_full
);
    import ldp_pkg::*;

    typedef enum logic [1:0] {MD_IDLE, MD_WORD0, MD_WORD1, MD_FULL} md_state_t;

    md_state_t state;
    logic      md_fire;

    // The stream is only open while one of the two words is awaited
    assign md_ready = (state == MD_WORD0) || (state == MD_WORD1);
    assign md_full  = (state == MD_FULL);
    assign md_fire  = md_valid & md_ready;

    // ======================================================================
    // Capture FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= MD_IDLE;
        end else if (frame_start) begin
            // A new frame drops the previous pair and opens the stream again
            state <= MD_WORD0;
        end else if (md_fire) begin
            if (state == MD_WORD0)
                state <= MD_WORD1;
            else
                state <= MD_FULL;
        end
    end

    // Payload registers follow the FSM
    always_ff @(posedge clk) begin
        if (md_fire && state == MD_WORD0)
            md.word0 <= md_data;
        if (md_fire && state == MD_WORD1)
            md.word1 <= md_data;
    end

    // The W side only starts a frame after it has sent the previous pair,
    // so a new frame never lands in the middle of a capture
    a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
        frame_start |-> !md_ready)
        else $error("frame_start arrived while metadata capture was under way");

endmodule

// ==== hw/aw_sequencer.sv ====
// Requests per frame are fixed by cfg.frame_size; the fd stream must hold valid until accepted
`timescale 1ns/1ps

module aw_sequencer (
    input  logic                       clk,
    input  logic                       resetn,
    input  ldp_pkg::ring_cfg_t         cfg,
    input  logic                       frame_idle,
    input  logic                       fd_valid,
    input  logic [ldp_pkg::ADDR_W-1:0] fd_addr,
    output ldp_pkg::aw_req_t           aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output logic                       fd_step
);
    import ldp_pkg::*;

    typedef enum logic [2:0] {AW_FIRST, AW_FD, AW_MD0, AW_MD1, AW_FC} aw_state_t;

    aw_state_t         state;
    logic [ADDR_W-1:0] fd_total;
    logic [ADDR_W-1:0] fd_cnt;
    logic [ADDR_W-1:0] md_off;
    logic [ADDR_W-1:0] md_next;
    logic              aw_fire;
    logic              start_req;
    logic              start_q;
    logic              start_rise;
    logic              start_pend;

    assign fd_total = cfg.frame_size / ADDR_W'(FD_BURST_BYTES);
    assign aw_fire  = aw_valid & aw_ready;
    assign fd_step  = aw_fire && (state == AW_FIRST || state == AW_FD);

    // A frame is announced once the W side waits with data ready.
    // The stream holds valid, so this rises exactly once per frame
    assign start_req  = frame_idle & fd_valid;
    assign start_rise = start_req & ~start_q;

    // Metadata slot for the next frame, wrapping at the ring size
    assign md_next = (md_off + ADDR_W'(MD_BURST_BYTES) >= cfg.md_size) ?
                     '0 : md_off + ADDR_W'(MD_BURST_BYTES);

    // ======================================================================
    // Request decode
    // ======================================================================
    always_comb begin
        aw_valid = 1'b1;
        aw.addr  = fd_addr;
        aw.len   = 8'(FD_BEATS - 1);
        case (state)
            // The pending flag keeps valid up once W has taken the first beat
            AW_FIRST: aw_valid = start_req | start_pend;
            AW_FD: ;
            AW_MD0: begin
                aw.addr = cfg.md0_base + md_off;
                aw.len  = 8'(MD_BEATS - 1);
            end
            AW_MD1: begin
                aw.addr = cfg.md1_base + md_off;
                aw.len  = 8'(MD_BEATS - 1);
            end
            AW_FC: begin
                aw.addr = cfg.fc_addr;
                aw.len  = 8'd0;
            end
            default: aw_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= AW_FIRST;
            fd_cnt     <= '0;
            md_off     <= '0;
            start_q    <= 1'b0;
            start_pend <= 1'b0;
        end else begin
            start_q <= start_req;
            // An accept in AW_FIRST consumes the announced frame, unless the
            // next frame is announced in the same cycle
            if (state == AW_FIRST && aw_fire)
                start_pend <= start_pend & start_rise;
            else
                start_pend <= start_pend | start_rise;

            if (aw_fire) begin
                case (state)
                    AW_FIRST, AW_FD: begin
                        if (fd_cnt + 1'b1 == fd_total) begin
                            fd_cnt <= '0;
                            state  <= AW_MD0;
                        end else begin
                            fd_cnt <= fd_cnt + 1'b1;
                            state  <= AW_FD;
                        end
                    end
                    AW_MD0: state <= AW_MD1;
                    AW_MD1: state <= AW_FC;
                    AW_FC: begin
                        md_off <= md_next;
                        state  <= AW_FIRST;
                    end
                    default: state <= AW_FIRST;
                endcase
            end
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!resetn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW request changed before it was accepted");

    // An INCR burst must not cross a 4 KB page of host memory
    a_aw_4k: assert property (@(posedge clk) disable iff (!resetn)
        aw_valid |->
        (32'(aw.addr[11:0]) + (32'(aw.len) + 1) * STRB_W) <= 4096)
        else $error("AW burst at 0x%0h crosses a 4 KB boundary", aw.addr);

endmodule

// ==== hw/w_sequencer.sv ====
// Frame data passes straight through; metadata beats wait for md_full, counter beat is 32 bits
`timescale 1ns/1ps

module w_sequencer (
    input  logic                       clk,
    input  logic                       resetn,
    input  ldp_pkg::ring_cfg_t         cfg,
    input  logic [ldp_pkg::DATA_W-1:0] fd_data,
    input  logic                       fd_valid,
    output logic                       fd_ready,
    input  ldp_pkg::md_pair_t          md,
    input  logic                       md_full,
    output ldp_pkg::w_beat_t           w,
    output logic                       w_valid,
    input  logic                       w_ready,
    output logic                       frame_idle,
    output logic                       frame_start
);
    import ldp_pkg::*;

    typedef enum logic [2:0] {
        W_IDLE, W_FD, W_MD00, W_MD01, W_MD10, W_MD11, W_FC
    } w_state_t;

    w_state_t                    state;
    logic [$clog2(FD_BEATS)-1:0] beat;
    logic [ADDR_W-1:0]           fd_total;
    logic [ADDR_W-1:0]           burst_cnt;
    logic [31:0]                 frame_cnt;
    logic                        w_fire;
    logic                        fd_last;
    logic                        in_md;

    assign fd_total    = cfg.frame_size / ADDR_W'(FD_BURST_BYTES);
    assign fd_last     = (beat == $bits(beat)'(FD_BEATS - 1));
    assign in_md       = state inside {W_MD00, W_MD01, W_MD10, W_MD11};
    assign w_fire      = w_valid & w_ready;
    assign frame_idle  = (state == W_IDLE);
    assign frame_start = frame_idle & w_fire;

    // ======================================================================
    // Beat mux
    // ======================================================================
    always_comb begin
        fd_ready = 1'b0;
        w_valid  = 1'b0;
        w.data   = fd_data;
        w.strb   = '1;
        w.last   = 1'b0;
        case (state)
            // Frame data goes through with no register in the path
            W_IDLE, W_FD: begin
                fd_ready = w_ready;
                w_valid  = fd_valid;
                w.last   = fd_last;
            end
            W_MD00, W_MD10: begin
                w_valid = md_full;
                w.data  = md.word0;
            end
            W_MD01, W_MD11: begin
                w_valid = md_full;
                w.data  = md.word1;
                w.last  = 1'b1;
            end
            // Same counter in both halves, so either 32-bit read sees it
            W_FC: begin
                w_valid = 1'b1;
                w.data  = {frame_cnt, frame_cnt};
                w.last  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= W_IDLE;
            beat      <= '0;
            burst_cnt <= '0;
            frame_cnt <= 32'd1;
        end else if (w_fire) begin
            case (state)
                W_IDLE, W_FD: begin
                    state <= W_FD;
                    if (fd_last) begin
                        beat <= '0;
                        // The last burst of the frame hands over to metadata
                        if (burst_cnt + 1'b1 == fd_total) begin
                            burst_cnt <= '0;
                            state     <= W_MD00;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                W_MD00: state <= W_MD01;
                W_MD01: state <= W_MD10;
                W_MD10: state <= W_MD11;
                W_MD11: state <= W_FC;
                W_FC: begin
                    frame_cnt <= frame_cnt + 1'b1;
                    state     <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Once the pair is held it must stay held until all four beats are out,
    // since md_capture only clears it on the next frame_start
    a_md_held: assert property (@(posedge clk) disable iff (!resetn)
        in_md && md_full |=> !in_md || md_full)
        else $error("md_full dropped while metadata beats were being sent");

endmodule

// ==== hw/ldp_manager.sv ====
// AXI write master with fixed size and burst codes; B responses are accepted and not checked
`timescale 1ns/1ps

module ldp_manager (
    input  logic                       clk,
    input  logic                       resetn,
    input  ldp_pkg::ring_cfg_t         cfg,

    // Frame-data stream
    input  logic [ldp_pkg::DATA_W-1:0] fd_data,
    input  logic                       fd_valid,
    output logic                       fd_ready,

    // Metadata stream
    input  logic [ldp_pkg::DATA_W-1:0] md_data,
    input  logic                       md_valid,
    output logic                       md_ready,

    // AXI write address
    output ldp_pkg::aw_req_t           aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,

    // AXI write data
    output ldp_pkg::w_beat_t           w,
    output logic                       w_valid,
    input  logic                       w_ready,

    // AXI write response
    input  logic                       b_valid,
    output logic                       b_ready
);
    import ldp_pkg::*;

    logic              frame_idle;
    logic              frame_start;
    logic              fd_step;
    logic              md_full;
    logic [ADDR_W-1:0] fd_addr;
    md_pair_t          md;

    assign b_ready = 1'b1;

    // ======================================================================
    // Writer blocks
    // ======================================================================
    fd_addr_gen u_fd_addr_gen (
        .clk     (clk),
        .resetn  (resetn),
        .cfg     (cfg),
        .fd_step (fd_step),
        .fd_addr (fd_addr)
    );

    md_capture u_md_capture (
        .clk         (clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .md_data     (md_data),
        .md_valid    (md_valid),
        .md_ready    (md_ready),
        .md          (md),
        .md_full     (md_full)
    );

    aw_sequencer u_aw_sequencer (
        .clk        (clk),
        .resetn     (resetn),
        .cfg        (cfg),
        .frame_idle (frame_idle),
        .fd_valid   (fd_valid),
        .fd_addr    (fd_addr),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .fd_step    (fd_step)
    );

    w_sequencer u_w_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .fd_data     (fd_data),
        .fd_valid    (fd_valid),
        .fd_ready    (fd_ready),
        .md          (md),
        .md_full     (md_full),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .frame_idle  (frame_idle),
        .frame_start (frame_start)
    );

endmodule

// ==== sim/tb_ldp_manager.sv ====
// Four frames per run on a fixed ring layout; B responses always OKAY; stalls come from a seeded $random
`timescale 1ns/1ps

module tb_ldp_manager;
    import ldp_pkg::*;

    // ======================================================================
    // Host-RAM layout and run geometry
    // ======================================================================
    localparam logic [63:0] FD0_BASE   = 64'h0000_1000;
    localparam logic [63:0] FD1_BASE   = 64'h0000_2000;
    localparam logic [63:0] MD0_BASE   = 64'h0000_3000;
    localparam logic [63:0] MD1_BASE   = 64'h0000_4000;
    localparam logic [63:0] FC_ADDR    = 64'h0000_5000;
    localparam int          FD_SIZE    = 2 * FD_BURST_BYTES;
    localparam int          MD_SIZE    = 2 * MD_BURST_BYTES;
    localparam int          FD_PER_FRM = 3;
    localparam int          FRAMES     = 4;
    // Per frame: the frame-data bursts, two metadata bursts and the counter
    localparam int AW_PER_FRM = FD_PER_FRM + 3;
    localparam int W_PER_FRM  = FD_PER_FRM * FD_BEATS + 2 * MD_BEATS + 1;
    localparam int AW_TOTAL   = FRAMES * AW_PER_FRM;
    localparam int W_TOTAL    = FRAMES * W_PER_FRM;
    localparam int FD_TOTAL   = FRAMES * FD_PER_FRM * FD_BEATS;
    localparam int MD_TOTAL   = FRAMES * 2;
    localparam int RUN_LIMIT  = 5000;

    logic              clk;
    logic              resetn;
    ring_cfg_t         cfg;
    logic [DATA_W-1:0] fd_data;
    logic              fd_valid;
    logic              fd_ready;
    logic [DATA_W-1:0] md_data;
    logic              md_valid;
    logic              md_ready;
    aw_req_t           aw;
    logic              aw_valid;
    logic              aw_ready;
    w_beat_t           w;
    logic              w_valid;
    logic              w_ready;
    logic              b_valid;
    logic              b_ready;

    // Transactions taken by the slave model, in order of acceptance
    aw_req_t aw_q[$];
    w_beat_t w_q[$];
    int      fd_idx;
    int      md_idx;
    int      b_cnt;
    int      w_bursts;
    bit      md_acc;
    bit      stall;
    bit      timed_out;
    integer  seed;
    int      checks;
    int      errors;

    ldp_manager dut0 (
        .clk(clk), .resetn(resetn), .cfg(cfg),
        .fd_data(fd_data), .fd_valid(fd_valid), .fd_ready(fd_ready),
        .md_data(md_data), .md_valid(md_valid), .md_ready(md_ready),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Stream contents, distinct for every index
    function automatic logic [63:0] fd_word(input int i);
        return {32'hfd00_0000 | 32'(i), 32'(i) * 32'h9e37_79b9};
    endfunction

    function automatic logic [63:0] md_word(input int i);
        return {32'h3d00_0000 | 32'(i), ~(32'(i) * 32'h0101_0101)};
    endfunction

    // Burst k of the run: four to ring 0, four to ring 1, each ring wrapping at FD_SIZE
    function automatic logic [63:0] exp_fd_addr(input int k);
        int          g;
        int          used;
        logic [63:0] off;
        g    = k % (2 * BURSTS_PER_GROUP);
        used = (k / (2 * BURSTS_PER_GROUP)) * BURSTS_PER_GROUP + (g % BURSTS_PER_GROUP);
        off  = 64'((used * FD_BURST_BYTES) % FD_SIZE);
        return (g < BURSTS_PER_GROUP) ? FD0_BASE + off : FD1_BASE + off;
    endfunction

    function automatic bit run_done();
        return (aw_q.size() == AW_TOTAL) && (w_q.size() == W_TOTAL) && (b_cnt == AW_TOTAL);
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s", what);
    endtask

    // ======================================================================
    // Slave model: records handshakes as seen at the rising edge
    // ======================================================================
    always @(posedge clk) begin
        if (resetn) begin
            if (aw_valid && aw_ready)
                aw_q.push_back(aw);
            if (w_valid && w_ready) begin
                w_q.push_back(w);
                if (w.last)
                    w_bursts++;
            end
            if (fd_valid && fd_ready)
                fd_idx++;
            if (md_valid && md_ready) begin
                md_idx++;
                md_acc = 1'b1;
            end
            if (b_valid && b_ready)
                b_cnt++;
        end
    end

    task automatic clear_inputs();
        fd_valid = 1'b0;
        fd_data  = '0;
        md_valid = 1'b0;
        md_data  = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
    endtask

    // Called on the falling edge; stalls are only drawn in back-pressure mode
    task automatic drive_inputs();
        aw_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
        w_ready  = stall ? (($random(seed) & 1) != 0) : 1'b1;
        fd_valid = (fd_idx < FD_TOTAL);
        fd_data  = fd_word(fd_idx);
        // A metadata word already offered stays on the bus until it is taken
        if (!(md_valid && !md_acc))
            md_valid = (md_idx < MD_TOTAL) && (!stall || (($random(seed) & 7) == 0));
        md_acc  = 1'b0;
        md_data = md_word(md_idx);
        // One response per burst, once both its request and its last beat are in
        b_valid = (b_cnt < w_bursts) && (b_cnt < aw_q.size());
    endtask

    // Resets the DUT and pushes four frames through it
    task automatic run_frames(input bit stall_mode);
        int cycles;
        @(negedge clk);
        resetn = 1'b0;
        clear_inputs();
        stall = stall_mode;
        aw_q.delete();
        w_q.delete();
        fd_idx   = 0;
        md_idx   = 0;
        b_cnt    = 0;
        w_bursts = 0;
        md_acc   = 1'b0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        cycles = 0;
        while (!run_done() && cycles < RUN_LIMIT) begin
            @(negedge clk);
            drive_inputs();
            cycles++;
        end
        if (!run_done())
            report_timeout("four frames did not complete on the AXI write channels");
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic check_reset_state();
        @(negedge clk);
        check_eq("aw_valid", 64'(aw_valid), 64'h0);
        check_eq("w_valid", 64'(w_valid), 64'h0);
        check_eq("fd_ready", 64'(fd_ready), 64'h0);
        check_eq("md_ready", 64'(md_ready), 64'h0);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_eq("aw_valid", 64'(aw_valid), 64'h0);
        check_eq("w_valid", 64'(w_valid), 64'h0);
        check_eq("fd_ready", 64'(fd_ready), 64'h0);
        check_eq("md_ready", 64'(md_ready), 64'h0);
        // Responses are always taken
        check_eq("b_ready", 64'(b_ready), 64'h1);
    endtask

    task automatic check_fd_addressing();
        aw_req_t a;
        for (int f = 0; f < FRAMES; f++) begin
            for (int j = 0; j < FD_PER_FRM; j++) begin
                a = aw_q[f * AW_PER_FRM + j];
                check_eq($sformatf("aw.addr[fd %0d]", f * FD_PER_FRM + j), a.addr,
                         exp_fd_addr(f * FD_PER_FRM + j));
                check_eq("aw.len", 64'(a.len), 64'(FD_BEATS - 1));
            end
        end
    endtask

    task automatic check_pass_through();
        w_beat_t b;
        int      i;
        for (int f = 0; f < FRAMES; f++) begin
            for (int k = 0; k < FD_PER_FRM * FD_BEATS; k++) begin
                b = w_q[f * W_PER_FRM + k];
                i = f * FD_PER_FRM * FD_BEATS + k;
                check_eq($sformatf("w.data[fd %0d]", i), b.data, fd_word(i));
                check_eq("w.strb", 64'(b.strb), 64'hff);
                check_eq($sformatf("w.last[fd %0d]", i), 64'(b.last),
                         64'((k % FD_BEATS) == FD_BEATS - 1));
            end
        end
    endtask

    task automatic check_metadata();
        aw_req_t     a;
        w_beat_t     b;
        logic [63:0] off;
        for (int f = 0; f < FRAMES; f++) begin
            // Both rings share one slot per frame
            off = 64'((f * MD_BURST_BYTES) % MD_SIZE);
            a = aw_q[f * AW_PER_FRM + FD_PER_FRM];
            check_eq("aw.addr[md0]", a.addr, MD0_BASE + off);
            check_eq("aw.len[md0]", 64'(a.len), 64'(MD_BEATS - 1));
            a = aw_q[f * AW_PER_FRM + FD_PER_FRM + 1];
            check_eq("aw.addr[md1]", a.addr, MD1_BASE + off);
            check_eq("aw.len[md1]", 64'(a.len), 64'(MD_BEATS - 1));
            for (int m = 0; m < 4; m++) begin
                b = w_q[f * W_PER_FRM + FD_PER_FRM * FD_BEATS + m];
                check_eq($sformatf("w.data[md %0d.%0d]", f, m), b.data, md_word(2 * f + m % 2));
                check_eq($sformatf("w.last[md %0d.%0d]", f, m), 64'(b.last), 64'(m % 2));
            end
        end
    endtask

    task automatic check_frame_counter();
        aw_req_t a;
        w_beat_t b;
        for (int f = 0; f < FRAMES; f++) begin
            a = aw_q[f * AW_PER_FRM + AW_PER_FRM - 1];
            check_eq("aw.addr[fc]", a.addr, FC_ADDR);
            check_eq("aw.len[fc]", 64'(a.len), 64'h0);
            b = w_q[f * W_PER_FRM + W_PER_FRM - 1];
            check_eq($sformatf("w.data[fc %0d]", f), b.data, {32'(f + 1), 32'(f + 1)});
            check_eq("w.strb[fc]", 64'(b.strb), 64'hff);
            check_eq("w.last[fc]", 64'(b.last), 64'h1);
        end
    endtask

    task automatic run_back_pressure();
        run_frames(1'b1);
        if (!timed_out) begin
            check_fd_addressing();
            check_pass_through();
            check_metadata();
            check_frame_counter();
        end
    endtask

    initial begin
        seed      = 32'h8a29;
        checks    = 0;
        errors    = 0;
        stall     = 1'b0;
        timed_out = 1'b0;
        resetn    = 1'b0;
        clear_inputs();
        cfg.fd0_base   = FD0_BASE;
        cfg.fd1_base   = FD1_BASE;
        cfg.fd_size    = 64'(FD_SIZE);
        cfg.md0_base   = MD0_BASE;
        cfg.md1_base   = MD1_BASE;
        cfg.md_size    = 64'(MD_SIZE);
        cfg.fc_addr    = FC_ADDR;
        cfg.frame_size = 64'(FD_PER_FRM * FD_BURST_BYTES);

        check_reset_state();
        run_frames(1'b0);
        if (!timed_out) begin
            check_fd_addressing();
            check_pass_through();
            check_metadata();
            check_frame_counter();
            run_back_pressure();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/ldp_pkg.sv
hw/fd_addr_gen.sv
hw/md_capture.sv
hw/aw_sequencer.sv
hw/w_sequencer.sv
hw/ldp_manager.sv
sim/tb_ldp_manager.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_ldp_manager -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ldp_manager)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation PASSED" <<< "$out"; then
    exit 0
fi
exit 1
